/* sim.f */
+incdir+tests
rtl/rv32_pkg.sv
rtl/rv32_decode.sv
rtl/rv32_regfile.sv
rtl/rv32_issue.sv
rtl/rv32_alu.sv
rtl/rv32_commit.sv
rtl/rv32_exec_core.sv
tests/rv32_exec_asserts.sv
tests/tb_rv32_exec_core.sv

/* tests/tb_rv32_model.svh */
`ifndef TB_RV32_MODEL_SVH
`define TB_RV32_MODEL_SVH

// Architectural result of one RV32I integer instruction
function automatic void model_exec
(
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        we,
    output logic        taken,
    output logic [31:0] target
);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i, imm_u, imm_b, imm_j, rhs;
    logic        legal, branch, sub;

    f3     = instr[14:12];
    f7     = instr[31:25];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_u  = {instr[31:12], 12'h000};
    imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    result = '0;
    target = '0;
    legal  = 1'b1;
    branch = 1'b0;
    taken  = 1'b0;

    case (instr[6:0])
        OPC_LUI:   result = imm_u;
        OPC_AUIPC: result = pc + imm_u;
        OPC_JAL:
        begin
            result = pc + 32'd4;
            taken  = 1'b1;
            target = pc + imm_j;
        end
        OPC_JALR:
        begin
            legal  = (f3 == 3'b000);
            result = pc + 32'd4;
            taken  = 1'b1;
            target = a + imm_i;
        end
        OPC_BRANCH:
        begin
            branch = 1'b1;
            target = pc + imm_b;
            case (f3)
                3'b000:  taken = (a == b);
                3'b001:  taken = (a != b);
                3'b100:  taken = ($signed(a) < $signed(b));
                3'b101:  taken = ($signed(a) >= $signed(b));
                3'b110:  taken = (a < b);
                3'b111:  taken = (a >= b);
                default: legal = 1'b0;
            endcase
        end
        OPC_OP_IMM, OPC_OP:
        begin
            rhs = (instr[6:0] == OPC_OP_IMM) ? imm_i : b;
            sub = (instr[6:0] == OPC_OP) && f7[5];
            // funct7 only matters for register ops and the immediate shifts
            if ((instr[6:0] == OPC_OP) || (f3 == 3'b001) || (f3 == 3'b101))
                legal = (f7 == 7'b0) || ((f7 == 7'b0100000) && ((f3 == 3'b000) || (f3 == 3'b101)));
            case (f3)
                3'b000:  result = sub ? (a - rhs) : (a + rhs);
                3'b001:  result = a << rhs[4:0];
                3'b010:  result = {31'b0, $signed(a) < $signed(rhs)};
                3'b011:  result = {31'b0, a < rhs};
                3'b100:  result = a ^ rhs;
                3'b101:
                begin
                    if (f7[5])
                        result = $signed(a) >>> rhs[4:0];
                    else
                        result = a >> rhs[4:0];
                end
                3'b110:  result = a | rhs;
                default: result = a & rhs;
            endcase
        end
        default: legal = 1'b0;
    endcase

    we     = legal && !branch && (instr[11:7] != 5'd0);
    taken  = taken && legal;
    target = {target[31:1], 1'b0};
endfunction

`endif

/* tests/tb_rv32_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv32_exec_core;
    import rv32_pkg::*;

    localparam int reset_cycles_lp = 10;
    localparam int num_instr_lp    = 2000;
    localparam int max_idle_lp     = 200;
    localparam int timeout_lp      = 2 * (reset_cycles_lp + num_instr_lp + max_idle_lp);

    typedef struct
    {
        int        due;
        int        idx;
        string     name;
        retire_s   ret;
        logic      taken;
        redirect_s redir;
    } expected_s;

    logic      clk = 1'b0;
    logic      reset;
    logic      instr_v;
    logic [31:0] instr;
    logic [31:0] pc;
    logic      retire_v;
    retire_s   retire;
    logic      redirect_v;
    redirect_s redirect;

    int          cycle = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    logic [31:0] rng_state = 32'd84;
    logic [31:0] model_regs [32];
    logic [31:0] pc_next = 32'h0000_1000;
    expected_s   exp_q [$];

    `include "tb_rv32_model.svh"

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    rv32_exec_core rv32_exec_core_i
    (
        .clk_i        (clk),
        .reset_i      (reset),
        .instr_v_i    (instr_v),
        .instr_i      (instr),
        .pc_i         (pc),
        .retire_v_o   (retire_v),
        .retire_o     (retire),
        .redirect_v_o (redirect_v),
        .redirect_o   (redirect)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Mostly x0 through x7 so that dependencies and x0 reads are frequent
    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[7:5] != 3'b000) ? {2'b00, r[2:0]} : r[4:0];
    endfunction

    function automatic void make_instr(output logic [31:0] word, output string name);
        logic [31:0] r, imm;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = next_rand();
        imm = next_rand();
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        f3  = r[14:12];
        f7  = ((f3 == 3'b000) || (f3 == 3'b101)) && r[15] ? 7'b0100000 : 7'b0000000;
        if (r[20:16] == 5'd0) // Load, store, fence and system are outside the slice
        begin
            name = "illegal";
            case (r[22:21])
                2'd0:    word = {imm[31:7], 7'b0000011};
                2'd1:    word = {imm[31:7], 7'b0100011};
                2'd2:    word = {imm[31:7], 7'b0001111};
                default: word = {imm[31:7], 7'b1110011};
            endcase
        end
        else if (r[3:0] < 4'd4)
        begin
            name = "op";
            word = {f7, rs2, rs1, f3, rd, OPC_OP};
        end
        else if (r[3:0] < 4'd8)
        begin
            name = "op_imm";
            if ((f3 == 3'b001) || (f3 == 3'b101))
                imm[11:5] = (f3 == 3'b101) ? f7 : 7'b0000000;
            word = {imm[11:0], rs1, f3, rd, OPC_OP_IMM};
        end
        else if (r[3:0] == 4'd8)
        begin
            name = "lui";
            word = {imm[31:12], rd, OPC_LUI};
        end
        else if (r[3:0] == 4'd9)
        begin
            name = "auipc";
            word = {imm[31:12], rd, OPC_AUIPC};
        end
        else if (r[3:0] == 4'd10)
        begin
            name = "jal";
            word = {imm[31:12], rd, OPC_JAL};
        end
        else if (r[3:0] == 4'd11)
        begin
            name = "jalr";
            word = {imm[11:0], rs1, 3'b000, rd, OPC_JALR};
        end
        else
        begin
            name = "branch";
            if (f3[2:1] == 2'b01)
                f3[1] = 1'b0; // Skip the two reserved funct3 values
            word = {imm[31:25], rs2, rs1, f3, imm[11:7], OPC_BRANCH};
        end
    endfunction

    task automatic drive_instr(input int n);
        logic [31:0] word, res, target;
        logic        we, taken;
        string       name;
        expected_s   e;
        make_instr(word, name);
        model_exec(word, pc_next, model_regs[word[19:15]], model_regs[word[24:20]],
                   res, we, taken, target);
        e.due          = cycle + 2;
        e.idx          = n;
        e.name         = name;
        e.ret.rd       = word[11:7];
        e.ret.data     = res;
        e.ret.we       = we;
        e.taken        = taken;
        e.redir.target = target;
        exp_q.push_back(e);
        if (we)
            model_regs[word[11:7]] = res;
        instr_v = 1'b1;
        instr   = word;
        pc      = pc_next;
        pc_next = pc_next + 32'd4;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Checking

    task automatic check_retire(input string name, input int idx, input retire_s exp_r,
                                input retire_s act_r);
        if ((act_r.rd !== exp_r.rd) || (act_r.we !== exp_r.we)
            || (exp_r.we && (act_r.data !== exp_r.data)))
        begin
            value_errors++;
            $display("FAILED %s #%0d retire: expected rd=%0d data=%h we=%b, %s",
                     name, idx, exp_r.rd, exp_r.data, exp_r.we,
                     $sformatf("actual rd=%0d data=%h we=%b", act_r.rd, act_r.data, act_r.we));
        end
    endtask

    task automatic check_redirect(input string name, input int idx, input redirect_s exp_r,
                                  input redirect_s act_r);
        if (act_r.target !== exp_r.target)
        begin
            value_errors++;
            $display("FAILED %s #%0d redirect: expected target=%h, actual target=%h",
                     name, idx, exp_r.target, act_r.target);
        end
    endtask

    task automatic check_outputs();
        expected_s e;
        if ((exp_q.size() > 0) && (exp_q[0].due == cycle))
        begin
            e = exp_q.pop_front();
            if (retire_v !== 1'b1)
            begin
                protocol_errors++;
                $display("No retire for %s #%0d in cycle %0d", e.name, e.idx, cycle);
            end
            else
                check_retire(e.name, e.idx, e.ret, retire);
            if (e.taken && (redirect_v !== 1'b1))
            begin
                protocol_errors++;
                $display("No redirect for taken %s #%0d in cycle %0d", e.name, e.idx, cycle);
            end
            else if (!e.taken && (redirect_v !== 1'b0))
            begin
                protocol_errors++;
                $display("Redirect for not-taken %s #%0d in cycle %0d", e.name, e.idx, cycle);
            end
            else if (e.taken)
                check_redirect(e.name, e.idx, e.redir, redirect);
        end
        else
        begin
            if (retire_v !== 1'b0)
            begin
                protocol_errors++;
                $display("Retire with no instruction due in cycle %0d", cycle);
            end
            if (redirect_v !== 1'b0)
            begin
                protocol_errors++;
                $display("Redirect with no instruction due in cycle %0d", cycle);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Run control

    initial
    begin
        wait (cycle >= timeout_lp);
        $display("Timeout after %0d cycles, the run did not complete", timeout_lp);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int          n;
        int          idle_used;
        int          assert_errors;
        logic [31:0] r;
        reset   = 1'b1;
        instr_v = 1'b0;
        instr   = '0;
        pc      = '0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        n         = 0;
        idle_used = 0;

        repeat (reset_cycles_lp) @(posedge clk);
        #1 reset = 1'b0;

        while (n < num_instr_lp)
        begin
            @(posedge clk);
            #1;
            check_outputs();
            r = next_rand();
            if ((r[2:0] == 3'b000) && (idle_used < max_idle_lp))
            begin
                instr_v = 1'b0;
                idle_used++;
            end
            else
            begin
                drive_instr(n);
                n++;
            end
        end

        repeat (4)
        begin
            @(posedge clk);
            #1;
            check_outputs();
            instr_v = 1'b0;
        end
        if (exp_q.size() != 0)
        begin
            protocol_errors += exp_q.size();
            $display("%0d instructions never retired", exp_q.size());
        end

        assert_errors = rv32_exec_core_i.commit_i.exec_asserts_i.fail_count;
        $display("Errors: %0d wrong values, %0d missing or unexpected, %0d assertion failures",
                 value_errors, protocol_errors, assert_errors);
        if ((value_errors == 0) && (protocol_errors == 0) && (assert_errors == 0))
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rv32_exec_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_asserts
(
    input logic              clk_i,
    input logic              reset_i,
    input logic              issue_valid_i,
    input logic              retire_v_i,
    input rv32_pkg::retire_s retire_i
);
    int fail_count = 0;

    // The retire strobe clears on the edge that samples reset
    retire_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !retire_v_i)
    else
    begin
        fail_count++;
        $error("retire_v_o is high after a reset edge");
    end

    no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
        retire_v_i |-> !(retire_i.we && (retire_i.rd == '0)))
    else
    begin
        fail_count++;
        $error("retire record writes x0");
    end

    retire_after_issue: assert property (@(posedge clk_i) disable iff (reset_i)
        retire_v_i |-> $past(issue_valid_i))
    else
    begin
        fail_count++;
        $error("retire without a valid issue record one cycle before");
    end

endmodule

bind rv32_commit rv32_exec_asserts exec_asserts_i
(
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_valid_i (issue_i.valid),
    .retire_v_i    (retire_v_o),
    .retire_i      (retire_o)
);

`default_nettype wire

/* rtl/rv32_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_exec_core
(
    input  logic                             clk_i,
    input  logic                             reset_i,
    input  logic                             instr_v_i,
    input  logic [31:0]                      instr_i,
    input  logic [rv32_pkg::pc_width_lp-1:0] pc_i,
    output logic                             retire_v_o,
    output rv32_pkg::retire_s                retire_o,
    output logic                             redirect_v_o,
    output rv32_pkg::redirect_s              redirect_o
);
    import rv32_pkg::*;

    decoded_op_s                  dec_op;
    logic [reg_width_lp-1:0]      rs1_data, rs2_data;
    issue_s                       issue;
    logic [reg_width_lp-1:0]      alu_result;
    logic [pc_width_lp-1:0]       jalr_target;
    logic                         jump_now;
    logic                         rf_we;
    logic [reg_addr_width_lp-1:0] rf_addr;
    logic [reg_width_lp-1:0]      rf_data;

    rv32_decode decode_i
    (
        .instr_i (instr_i),
        .op_o    (dec_op)
    );

    rv32_regfile regfile_i
    (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (dec_op.rs1),
        .rs2_addr_i (dec_op.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .wr_addr_i  (rf_addr),
        .wr_data_i  (rf_data)
    );

    rv32_issue issue_i
    (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .instr_v_i    (instr_v_i),
        .op_i         (dec_op),
        .pc_i         (pc_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .exe_result_i (alu_result),
        .issue_o      (issue)
    );

    rv32_alu alu_i
    (
        .issue_i       (issue),
        .result_o      (alu_result),
        .jalr_target_o (jalr_target),
        .jump_now_o    (jump_now)
    );

    rv32_commit commit_i
    (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .issue_i       (issue),
        .result_i      (alu_result),
        .jalr_target_i (jalr_target),
        .jump_now_i    (jump_now),
        .retire_v_o    (retire_v_o),
        .retire_o      (retire_o),
        .redirect_v_o  (redirect_v_o),
        .redirect_o    (redirect_o),
        .rf_we_o       (rf_we),
        .rf_addr_o     (rf_addr),
        .rf_data_o     (rf_data)
    );

endmodule

`default_nettype wire

/* rtl/rv32_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_commit
(
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  rv32_pkg::issue_s                       issue_i,
    input  logic [rv32_pkg::reg_width_lp-1:0]      result_i,
    input  logic [rv32_pkg::pc_width_lp-1:0]       jalr_target_i,
    input  logic                                   jump_now_i,
    output logic                                   retire_v_o,
    output rv32_pkg::retire_s                      retire_o,
    output logic                                   redirect_v_o,
    output rv32_pkg::redirect_s                    redirect_o,
    output logic                                   rf_we_o,
    output logic [rv32_pkg::reg_addr_width_lp-1:0] rf_addr_o,
    output logic [rv32_pkg::reg_width_lp-1:0]      rf_data_o
);
    import rv32_pkg::*;

    logic [pc_width_lp-1:0] pc_rel_target;
    logic [pc_width_lp-1:0] target;

    // Branches and JAL are PC relative
    assign pc_rel_target = issue_i.pc + issue_i.op.imm;
    assign target        = (issue_i.op.alu_op == ALU_JALR) ? jalr_target_i
                                                           : {pc_rel_target[pc_width_lp-1:1], 1'b0};

    // Write lands on the same edge that loads the retire record
    assign rf_we_o   = issue_i.valid && issue_i.op.writes_rd;
    assign rf_addr_o = issue_i.op.rd;
    assign rf_data_o = result_i;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            retire_v_o   <= 1'b0;
            redirect_v_o <= 1'b0;
        end
        else
        begin
            retire_v_o   <= issue_i.valid;
            redirect_v_o <= issue_i.valid && jump_now_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (issue_i.valid)
        begin
            retire_o.rd       <= issue_i.op.rd;
            retire_o.data     <= result_i;
            retire_o.we       <= issue_i.op.writes_rd;
            redirect_o.target <= target;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv32_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_alu
(
    input  rv32_pkg::issue_s                  issue_i,
    output logic [rv32_pkg::reg_width_lp-1:0] result_o,
    output logic [rv32_pkg::pc_width_lp-1:0]  jalr_target_o,
    output logic                              jump_now_o
);
    import rv32_pkg::*;

    alu_op_e                 alu_op;
    logic [reg_width_lp-1:0] rs1, rs2, op2;
    logic [reg_width_lp-1:0] adder_in;
    logic [reg_width_lp:0]   sum;
    logic                    carry;
    logic                    sub_not_add;
    logic                    sign_ex_or_zero;
    logic [4:0]              sh_amount;
    logic [reg_width_lp:0]   shr_out;
    logic [reg_width_lp-1:0] shl_out, xor_out, and_out, or_out;
    logic [pc_width_lp-1:0]  pc_plus4;
    logic                    rs1_eq_rs2, rs1_lt_rs2_signed, rs1_lt_rs2_unsigned;

    assign alu_op = issue_i.op.alu_op;
    assign rs1    = issue_i.rs1_val;
    assign rs2    = issue_i.rs2_val;

    // ~~~~~~~~~~~~~~~~~~~~
    // Datapath
    assign op2 = issue_i.op.use_imm ? issue_i.op.imm : rs2;

    assign sub_not_add     = alu_op inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign sign_ex_or_zero = (alu_op == ALU_SRA) & rs1[31];
    assign adder_in        = sub_not_add ? ~op2 : op2;

    // The 33-bit signed sum gives SLT and its carry out gives the unsigned compare
    assign {carry, sum} = {1'b0, rs1[31], rs1} + {1'b0, adder_in[31], adder_in}
                          + 34'(sub_not_add);

    assign sh_amount = op2[4:0];
    assign shr_out   = $signed({sign_ex_or_zero, rs1}) >>> sh_amount;
    assign shl_out   = rs1 << sh_amount;
    assign xor_out   = rs1 ^ op2;
    assign and_out   = rs1 & op2;
    assign or_out    = rs1 | op2;
    assign pc_plus4  = issue_i.pc + pc_width_lp'(4);

    always_comb
    begin
        case (alu_op)
            ALU_LUI:               result_o = issue_i.op.imm;
            ALU_AUIPC:             result_o = issue_i.pc + issue_i.op.imm;
            ALU_ADD, ALU_SUB:      result_o = sum[reg_width_lp-1:0];
            ALU_SLT:               result_o = {{(reg_width_lp-1){1'b0}}, sum[reg_width_lp]};
            ALU_SLTU:              result_o = {{(reg_width_lp-1){1'b0}}, ~carry};
            ALU_XOR:               result_o = xor_out;
            ALU_OR:                result_o = or_out;
            ALU_AND:               result_o = and_out;
            ALU_SLL:               result_o = shl_out;
            ALU_SRL, ALU_SRA:      result_o = shr_out[reg_width_lp-1:0];
            ALU_JAL, ALU_JALR:     result_o = pc_plus4; // Link value
            default:               result_o = '0;
        endcase
    end

    // JALR decodes with use_imm set, so the adder already holds rs1 plus the immediate
    assign jalr_target_o = {sum[pc_width_lp-1:1], 1'b0};

    // ~~~~~~~~~~~~~~~~~~~~
    // Branch compare
    assign rs1_eq_rs2          = (rs1 == rs2);
    assign rs1_lt_rs2_unsigned = (rs1 < rs2);
    assign rs1_lt_rs2_signed   = ($signed(rs1) < $signed(rs2));

    always_comb
    begin
        case (alu_op)
            ALU_BEQ:            jump_now_o = rs1_eq_rs2;
            ALU_BNE:            jump_now_o = ~rs1_eq_rs2;
            ALU_BLT:            jump_now_o = rs1_lt_rs2_signed;
            ALU_BGE:            jump_now_o = ~rs1_lt_rs2_signed;
            ALU_BLTU:           jump_now_o = rs1_lt_rs2_unsigned;
            ALU_BGEU:           jump_now_o = ~rs1_lt_rs2_unsigned;
            ALU_JAL, ALU_JALR:  jump_now_o = 1'b1;
            default:            jump_now_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv32_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_issue
(
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              instr_v_i,
    input  rv32_pkg::decoded_op_s             op_i,
    input  logic [rv32_pkg::pc_width_lp-1:0]  pc_i,
    input  logic [rv32_pkg::reg_width_lp-1:0] rs1_data_i,
    input  logic [rv32_pkg::reg_width_lp-1:0] rs2_data_i,
    input  logic [rv32_pkg::reg_width_lp-1:0] exe_result_i,
    output rv32_pkg::issue_s                  issue_o
);
    import rv32_pkg::*;

    logic                    exe_writes;
    logic                    fwd_rs1, fwd_rs2;
    logic [reg_width_lp-1:0] rs1_val, rs2_val;

    // ~~~~~~~~~~~~~~~~~~~~
    // Forwarding from execute

    // The register file is written at the end of this cycle, so its read is stale
    assign exe_writes = issue_o.valid && issue_o.op.writes_rd;
    assign fwd_rs1    = exe_writes && (issue_o.op.rd == op_i.rs1);
    assign fwd_rs2    = exe_writes && (issue_o.op.rd == op_i.rs2);

    assign rs1_val = fwd_rs1 ? exe_result_i : rs1_data_i;
    assign rs2_val = fwd_rs2 ? exe_result_i : rs2_data_i;

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
            issue_o.valid <= 1'b0;
        else
            issue_o.valid <= instr_v_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (instr_v_i)
        begin
            issue_o.op      <= op_i;
            issue_o.pc      <= pc_i;
            issue_o.rs1_val <= rs1_val;
            issue_o.rs2_val <= rs2_val;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv32_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_regfile
(
    input  logic                                   clk_i,
    input  logic                                   reset_i,
    input  logic [rv32_pkg::reg_addr_width_lp-1:0] rs1_addr_i,
    input  logic [rv32_pkg::reg_addr_width_lp-1:0] rs2_addr_i,
    output logic [rv32_pkg::reg_width_lp-1:0]      rs1_data_o,
    output logic [rv32_pkg::reg_width_lp-1:0]      rs2_data_o,
    input  logic                                   we_i,
    input  logic [rv32_pkg::reg_addr_width_lp-1:0] wr_addr_i,
    input  logic [rv32_pkg::reg_width_lp-1:0]      wr_data_i
);
    import rv32_pkg::*;

    logic [reg_width_lp-1:0] mem [2**reg_addr_width_lp];

    always_ff @(posedge clk_i)
    begin
        if (reset_i)
        begin
            for (int i = 0; i < 2**reg_addr_width_lp; i++)
                mem[i] <= '0;
        end
        else if (we_i && (wr_addr_i != '0)) // x0 keeps its reset value
        begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = mem[rs1_addr_i];
    assign rs2_data_o = mem[rs2_addr_i];

endmodule

`default_nettype wire

/* rtl/rv32_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv32_decode
(
    input  logic [31:0]           instr_i,
    output rv32_pkg::decoded_op_s op_o
);
    import rv32_pkg::*;

    rv32_opcode_e            opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [reg_width_lp-1:0] imm_i, imm_u, imm_b, imm_j;
    alu_op_e                 alu_op;
    logic [reg_width_lp-1:0] imm;
    logic                    use_imm;
    logic                    is_branch;

    assign opcode = rv32_opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ~~~~~~~~~~~~~~~~~~~~
    // Immediate formats
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb
    begin
        alu_op  = ALU_NOP;
        imm     = imm_i;
        use_imm = 1'b0;

        case (opcode)
            OPC_LUI:
            begin
                alu_op = ALU_LUI;
                imm    = imm_u;
            end
            OPC_AUIPC:
            begin
                alu_op = ALU_AUIPC;
                imm    = imm_u;
            end
            OPC_JAL:
            begin
                alu_op = ALU_JAL;
                imm    = imm_j;
            end
            OPC_JALR:
            begin
                alu_op  = (funct3 == 3'b000) ? ALU_JALR : ALU_NOP;
                use_imm = 1'b1; // Target comes out of the ALU adder
            end
            OPC_BRANCH:
            begin
                imm = imm_b;
                case (funct3)
                    3'b000:  alu_op = ALU_BEQ;
                    3'b001:  alu_op = ALU_BNE;
                    3'b100:  alu_op = ALU_BLT;
                    3'b101:  alu_op = ALU_BGE;
                    3'b110:  alu_op = ALU_BLTU;
                    3'b111:  alu_op = ALU_BGEU;
                    default: alu_op = ALU_NOP;
                endcase
            end
            OPC_OP_IMM:
            begin
                use_imm = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    3'b001:  alu_op = (funct7 == 7'b0000000) ? ALU_SLL : ALU_NOP;
                    default: alu_op = (funct7 == 7'b0000000) ? ALU_SRL :
                                      (funct7 == 7'b0100000) ? ALU_SRA : ALU_NOP;
                endcase
            end
            OPC_OP:
            begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_001: alu_op = ALU_SLL;
                    10'b0000000_010: alu_op = ALU_SLT;
                    10'b0000000_011: alu_op = ALU_SLTU;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_101: alu_op = ALU_SRL;
                    10'b0100000_101: alu_op = ALU_SRA;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_111: alu_op = ALU_AND;
                    default:         alu_op = ALU_NOP;
                endcase
            end
            default:
            begin
                alu_op = ALU_NOP; // Anything outside the integer subset
            end
        endcase
    end

    assign is_branch = alu_op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU};

    assign op_o.alu_op    = alu_op;
    assign op_o.rd        = instr_i[11:7];
    assign op_o.rs1       = instr_i[19:15];
    assign op_o.rs2       = instr_i[24:20];
    assign op_o.imm       = imm;
    assign op_o.use_imm   = use_imm;
    assign op_o.writes_rd = (alu_op != ALU_NOP) && !is_branch && (instr_i[11:7] != '0);

endmodule

`default_nettype wire

/* rtl/rv32_pkg.sv */
`default_nettype none

package rv32_pkg;

    localparam int reg_width_lp      = 32;
    localparam int reg_addr_width_lp = 5;
    localparam int pc_width_lp       = 32;

    // ~~~~~~~~~~~~~~~~~~~~
    // Encodings

    // Major opcodes handled by the execute slice
    typedef enum logic [6:0]
    {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } rv32_opcode_e;

    typedef enum logic [4:0]
    {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_AUIPC,
        ALU_JAL,
        ALU_JALR,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pipeline records

    typedef struct packed
    {
        alu_op_e                      alu_op;
        logic [reg_addr_width_lp-1:0] rd;
        logic [reg_addr_width_lp-1:0] rs1;
        logic [reg_addr_width_lp-1:0] rs2;
        logic [reg_width_lp-1:0]      imm;       // Sign extended and already shifted for U type
        logic                         use_imm;
        logic                         writes_rd; // Low for branches, NOP and rd of zero
    } decoded_op_s;

    typedef struct packed
    {
        logic                    valid;
        decoded_op_s             op;
        logic [pc_width_lp-1:0]  pc;
        logic [reg_width_lp-1:0] rs1_val;
        logic [reg_width_lp-1:0] rs2_val;
    } issue_s;

    typedef struct packed
    {
        logic [reg_addr_width_lp-1:0] rd;
        logic [reg_width_lp-1:0]      data;
        logic                         we;
    } retire_s;

    // Target is a byte address with bit 0 clear
    typedef struct packed
    {
        logic [pc_width_lp-1:0] target;
    } redirect_s;

endpackage

`default_nettype wire
